// File: Makefile
# Verilator build and run for the memory fabric

VERILATOR ?= verilator
TOP       ?= tb_fabric
RTL_TOP   ?= fabric_top
FILELIST  ?= soc_fabric.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/boot_rom.sv
// boot ROM
// fixed word table from the ROM image, read one cycle after the enable

`timescale 1ns/1ps
`default_nettype none

`include "rom_image.svh"

module boot_rom (
  input  logic                                 clk_i,
  input  logic                                 en_i,
  input  logic [$clog2(map_pkg::RomWords)-1:0] index_i,
  output logic [bus_pkg::DataWidth-1:0]        rdata_o
);

  import bus_pkg::*;
  import map_pkg::*;

  localparam logic [DataWidth-1:0] RomTable [RomWords] = `ROM_IMAGE_WORDS;

  // registered read, the word holds while idle
  always_ff @(posedge clk_i) begin
    if (en_i) begin
      rdata_o <= RomTable[index_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/bus_pkg.sv
// request and response channel widths
// credit counts for both directions and the response buffer depth

`default_nettype none

package bus_pkg;

  // ----------------------------------------------------------------------
  // data path
  // ----------------------------------------------------------------------
  localparam int unsigned AddrWidth      = 32;
  localparam int unsigned DataWidth      = 64;
  localparam int unsigned StrbWidth      = DataWidth / 8;
  // byte offset bits below one word
  localparam int unsigned WordOffsetBits = $clog2(StrbWidth);

  // ----------------------------------------------------------------------
  // flow control
  // ----------------------------------------------------------------------
  // request buffer depth, also the master's credits out of reset
  localparam int unsigned ReqCredits = 4;

  // response credits held by the fabric out of reset
  localparam int unsigned RspCredits = 4;
  localparam int unsigned RspDepth   = 4;

endpackage

`default_nettype wire

// File: rtl/data_sram.sv
// main SRAM
// single port word memory with byte-masked writes and a registered read

`timescale 1ns/1ps
`default_nettype none

module data_sram (
  input  logic                                  clk_i,
  input  logic                                  en_i,
  input  logic                                  we_i,
  input  logic [$clog2(map_pkg::SramWords)-1:0] index_i,
  input  logic [bus_pkg::DataWidth-1:0]         wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0]         be_i,
  output logic [bus_pkg::DataWidth-1:0]         rdata_o
);

  import bus_pkg::*;
  import map_pkg::*;

  logic [DataWidth-1:0] mem_q [SramWords];

  // ----------------------------------------------------------------------
  // write port, one byte lane per enable bit
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // read port
  // ----------------------------------------------------------------------
  // data shows up the cycle after the enable
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rdata_o <= mem_q[index_i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/fabric_top.sv
// memory fabric top level
// request buffer, router, boot ROM, main SRAM and response buffer

`timescale 1ns/1ps
`default_nettype none

module fabric_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_valid_i,
  input  logic                          req_we_i,
  input  logic [bus_pkg::AddrWidth-1:0] req_addr_i,
  input  logic [bus_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0] req_be_i,
  output logic                          req_credit_o,
  input  logic                          rsp_credit_i,
  output logic                          rsp_valid_o,
  output logic [bus_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                          rsp_err_o
);

  import bus_pkg::*;
  import map_pkg::*;

  // buffered request head
  logic                 head_valid, head_we, pop, slot_free;
  logic [AddrWidth-1:0] head_addr;
  logic [DataWidth-1:0] head_wdata;
  logic [StrbWidth-1:0] head_be;

  // memory ports
  logic                         rom_en, sram_en, sram_we;
  logic [$clog2(RomWords)-1:0]  rom_index;
  logic [$clog2(SramWords)-1:0] sram_index;
  logic [DataWidth-1:0]         rom_rdata, sram_rdata, sram_wdata;
  logic [StrbWidth-1:0]         sram_be;

  // response push
  logic                 push, push_err;
  logic [DataWidth-1:0] push_rdata;

  req_ingress i_req_ingress (
    .clk_i, .rst_ni,
    .req_valid_i, .req_we_i, .req_addr_i, .req_wdata_i, .req_be_i,
    .head_valid_o(head_valid), .head_we_o(head_we), .head_addr_o(head_addr),
    .head_wdata_o(head_wdata), .head_be_o(head_be),
    .pop_i(pop), .req_credit_o
  );

  region_router i_region_router (
    .clk_i, .rst_ni,
    .head_valid_i(head_valid), .head_we_i(head_we), .head_addr_i(head_addr),
    .head_wdata_i(head_wdata), .head_be_i(head_be),
    .pop_o(pop), .slot_free_i(slot_free),
    .rom_en_o(rom_en), .rom_index_o(rom_index), .rom_rdata_i(rom_rdata),
    .sram_en_o(sram_en), .sram_we_o(sram_we), .sram_index_o(sram_index),
    .sram_wdata_o(sram_wdata), .sram_be_o(sram_be), .sram_rdata_i(sram_rdata),
    .push_o(push), .push_rdata_o(push_rdata), .push_err_o(push_err)
  );

  boot_rom i_boot_rom (
    .clk_i, .en_i(rom_en), .index_i(rom_index), .rdata_o(rom_rdata)
  );

  data_sram i_data_sram (
    .clk_i, .en_i(sram_en), .we_i(sram_we), .index_i(sram_index),
    .wdata_i(sram_wdata), .be_i(sram_be), .rdata_o(sram_rdata)
  );

  rsp_egress i_rsp_egress (
    .clk_i, .rst_ni,
    .push_i(push), .push_rdata_i(push_rdata), .push_err_i(push_err),
    .slot_free_o(slot_free), .rsp_credit_i,
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o
  );

endmodule

`default_nettype wire

// File: rtl/map_pkg.sv
// address map of the fabric
// boot ROM and main SRAM windows, sizes in bytes and in words

`default_nettype none

package map_pkg;

  // ----------------------------------------------------------------------
  // boot ROM
  // ----------------------------------------------------------------------
  localparam logic [bus_pkg::AddrWidth-1:0] RomBase = 32'h0001_0000;
  localparam int unsigned RomLength = 128;
  localparam int unsigned RomWords  = RomLength / bus_pkg::StrbWidth;

  // ----------------------------------------------------------------------
  // main SRAM
  // ----------------------------------------------------------------------
  localparam logic [bus_pkg::AddrWidth-1:0] SramBase = 32'h8000_0000;
  // 8 KiB
  localparam int unsigned SramLength = 8 * 1024;
  localparam int unsigned SramWords  = SramLength / bus_pkg::StrbWidth;

  // anything outside these two windows is answered with an error

endpackage

`default_nettype wire

// File: rtl/region_router.sv
// address decode and memory dispatch
// pops the buffered request, drives ROM or SRAM, and pushes the
// response with its error flag one cycle later

`timescale 1ns/1ps
`default_nettype none

module region_router (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  head_valid_i,
  input  logic                                  head_we_i,
  input  logic [bus_pkg::AddrWidth-1:0]         head_addr_i,
  input  logic [bus_pkg::DataWidth-1:0]         head_wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0]         head_be_i,
  output logic                                  pop_o,
  input  logic                                  slot_free_i,
  output logic                                  rom_en_o,
  output logic [$clog2(map_pkg::RomWords)-1:0]  rom_index_o,
  input  logic [bus_pkg::DataWidth-1:0]         rom_rdata_i,
  output logic                                  sram_en_o,
  output logic                                  sram_we_o,
  output logic [$clog2(map_pkg::SramWords)-1:0] sram_index_o,
  output logic [bus_pkg::DataWidth-1:0]         sram_wdata_o,
  output logic [bus_pkg::StrbWidth-1:0]         sram_be_o,
  input  logic [bus_pkg::DataWidth-1:0]         sram_rdata_i,
  output logic                                  push_o,
  output logic [bus_pkg::DataWidth-1:0]         push_rdata_o,
  output logic                                  push_err_o
);

  import bus_pkg::*;
  import map_pkg::*;

  logic [AddrWidth-1:0] rom_offset;
  logic [AddrWidth-1:0] sram_offset;
  logic                 rom_hit;
  logic                 sram_hit;
  logic                 decode_err;

  // state of the access in flight
  logic inflight_q;
  logic rom_rd_q;
  logic sram_rd_q;
  logic err_q;

  // ----------------------------------------------------------------------
  // decode
  // ----------------------------------------------------------------------
  // below a base the offset wraps high, so one compare checks both ends
  assign rom_offset  = head_addr_i - RomBase;
  assign sram_offset = head_addr_i - SramBase;
  assign rom_hit     = (rom_offset < AddrWidth'(RomLength));
  assign sram_hit    = (sram_offset < AddrWidth'(SramLength));

  // unmapped, or a store into the ROM
  assign decode_err = !(rom_hit || sram_hit) || (rom_hit && head_we_i);

  assign pop_o = head_valid_i && slot_free_i;

  // ----------------------------------------------------------------------
  // memory dispatch
  // ----------------------------------------------------------------------
  assign rom_en_o    = pop_o && rom_hit && !head_we_i;
  assign rom_index_o = rom_offset[WordOffsetBits +: $clog2(RomWords)];

  assign sram_en_o    = pop_o && sram_hit;
  assign sram_we_o    = head_we_i;
  assign sram_index_o = sram_offset[WordOffsetBits +: $clog2(SramWords)];
  assign sram_wdata_o = head_wdata_i;
  assign sram_be_o    = head_be_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
      rom_rd_q   <= 1'b0;
      sram_rd_q  <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      inflight_q <= pop_o;
      rom_rd_q   <= rom_en_o;
      sram_rd_q  <= sram_en_o && !head_we_i;
      err_q      <= pop_o && decode_err;
    end
  end

  // ----------------------------------------------------------------------
  // response push
  // ----------------------------------------------------------------------
  // writes and errors carry zero data
  always_comb begin
    push_rdata_o = '0;
    if (rom_rd_q) begin
      push_rdata_o = rom_rdata_i;
    end else if (sram_rd_q) begin
      push_rdata_o = sram_rdata_i;
    end
  end

  assign push_o     = inflight_q;
  assign push_err_o = err_q;

endmodule

`default_nettype wire

// File: rtl/req_ingress.sv
// request buffer
// circular store for credited requests, head offered to the router,
// one credit pulse back to the master per popped entry

`timescale 1ns/1ps
`default_nettype none

module req_ingress (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          req_valid_i,
  input  logic                          req_we_i,
  input  logic [bus_pkg::AddrWidth-1:0] req_addr_i,
  input  logic [bus_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [bus_pkg::StrbWidth-1:0] req_be_i,
  output logic                          head_valid_o,
  output logic                          head_we_o,
  output logic [bus_pkg::AddrWidth-1:0] head_addr_o,
  output logic [bus_pkg::DataWidth-1:0] head_wdata_o,
  output logic [bus_pkg::StrbWidth-1:0] head_be_o,
  input  logic                          pop_i,
  output logic                          req_credit_o
);

  import bus_pkg::*;

  logic                 we_q    [ReqCredits];
  logic [AddrWidth-1:0] addr_q  [ReqCredits];
  logic [DataWidth-1:0] wdata_q [ReqCredits];
  logic [StrbWidth-1:0] be_q    [ReqCredits];

  // depth is a power of two so the pointers wrap by themselves
  logic [$clog2(ReqCredits)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(ReqCredits):0]   count_q;
  logic                          credit_q;

  // master only sends while holding a credit, so a slot is always free
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      we_q[wr_ptr_q]    <= req_we_i;
      addr_q[wr_ptr_q]  <= req_addr_i;
      wdata_q[wr_ptr_q] <= req_wdata_i;
      be_q[wr_ptr_q]    <= req_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({req_valid_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // freed slot goes back as a credit one cycle later
      credit_q <= pop_i;
    end
  end

  assign head_valid_o = (count_q != '0);
  assign head_we_o    = we_q[rd_ptr_q];
  assign head_addr_o  = addr_q[rd_ptr_q];
  assign head_wdata_o = wdata_q[rd_ptr_q];
  assign head_be_o    = be_q[rd_ptr_q];
  assign req_credit_o = credit_q;

endmodule

`default_nettype wire

// File: rtl/rom_image.svh
// boot ROM image, one 64-bit word per entry, lowest address first
// expands to an array literal for a table of RomWords entries

`ifndef ROM_IMAGE_SVH
`define ROM_IMAGE_SVH

`define ROM_IMAGE_WORDS '{ \
  64'h0010_029b_0000_0517, \
  64'h01f2_9293_0202_8293, \
  64'hf140_2573_0000_0597, \
  64'h0205_8593_0002_8067, \
  64'h8000_0537_0ff0_000f, \
  64'h0005_3583_0085_3603, \
  64'h00b6_0633_00c5_3823, \
  64'h1050_0073_ffdf_f06f, \
  64'hdead_beef_cafe_f00d, \
  64'h0123_4567_89ab_cdef, \
  64'h5a5a_a5a5_3c3c_c3c3, \
  64'h0000_0000_ffff_ffff, \
  64'h1357_9bdf_2468_ace0, \
  64'h8001_0002_4003_2004, \
  64'hfedc_ba98_7654_3210, \
  64'h7f7f_0101_8080_fefe  \
}

`endif

// File: rtl/rsp_egress.sv
// response buffer
// in-order FIFO that releases one response per cycle against the
// credits returned by the master

`timescale 1ns/1ps
`default_nettype none

module rsp_egress (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          push_i,
  input  logic [bus_pkg::DataWidth-1:0] push_rdata_i,
  input  logic                          push_err_i,
  output logic                          slot_free_o,
  input  logic                          rsp_credit_i,
  output logic                          rsp_valid_o,
  output logic [bus_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                          rsp_err_o
);

  import bus_pkg::*;

  logic [DataWidth-1:0] rdata_q [RspDepth];
  logic                 err_q   [RspDepth];

  logic [$clog2(RspDepth)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(RspDepth):0]   count_q;
  logic [$clog2(RspDepth):0]   reserved;
  logic [$clog2(RspCredits):0] credit_q;
  logic                        emit;

  // stored entries plus the push landing this cycle
  assign reserved    = count_q + {{$clog2(RspDepth){1'b0}}, push_i};
  assign slot_free_o = (reserved < RspDepth);

  assign emit = (count_q != '0) && (credit_q != '0);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      rdata_q[wr_ptr_q] <= push_rdata_i;
      err_q[wr_ptr_q]   <= push_err_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= ($clog2(RspCredits)+1)'(RspCredits);
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (emit) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, emit})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // one credit spent per response, one back per master pulse
      case ({emit, rsp_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign rsp_valid_o = emit;
  assign rsp_rdata_o = rdata_q[rd_ptr_q];
  assign rsp_err_o   = err_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: soc_fabric.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/map_pkg.sv
rtl/req_ingress.sv
rtl/region_router.sv
rtl/boot_rom.sv
rtl/data_sram.sv
rtl/rsp_egress.sv
rtl/fabric_top.sv
testbench/tb_fabric.sv

// File: testbench/tb_fabric.sv
// testbench for the memory fabric
// ROM, SRAM and unmapped traffic against a reference model, an in-order
// response checker, credit handling for both channels and a watchdog

`timescale 1ns/1ps
`default_nettype none

`include "rom_image.svh"

module tb_fabric;

  import bus_pkg::*;
  import map_pkg::*;

  localparam int ClkPeriod    = 4;
  localparam int ResetCycles  = 8;
  localparam int RomIdxBits   = $clog2(RomWords);
  localparam int SramIdxBits  = $clog2(SramWords);
  localparam int NumSramWords = 24;
  localparam int NumUnmapped  = 14;
  localparam int NumRomWrites = 8;
  localparam int NumMixed     = 48;
  localparam int NumRequests  = 2 * RomWords + 3 * NumSramWords + NumUnmapped
                                + NumRomWrites + NumMixed;
  // per-request cycle bound under heavy credit withholding
  localparam int CyclesPerReq = 40;
  localparam int TimeLimit    = (ResetCycles + NumRequests * CyclesPerReq) * ClkPeriod;
  localparam logic [31:0] Seed = 32'h143f_663f;

  localparam logic [DataWidth-1:0] RomImage [RomWords] = `ROM_IMAGE_WORDS;

  logic                 clk_i, rst_ni;
  logic                 req_valid_i, req_we_i, req_credit_o;
  logic [AddrWidth-1:0] req_addr_i;
  logic [DataWidth-1:0] req_wdata_i;
  logic [StrbWidth-1:0] req_be_i;
  logic                 rsp_credit_i, rsp_valid_o, rsp_err_o;
  logic [DataWidth-1:0] rsp_rdata_o;

  // reference model state
  logic [DataWidth-1:0]   sram_model [SramWords];
  logic [DataWidth:0]     exp_q [$];
  logic [DataWidth:0]     exp_rsp;
  logic [SramIdxBits-1:0] written_q [$];
  logic [31:0]            stim_rng, credit_rng;
  int                     req_credits, fab_credits, free_slots;
  int                     issued, credits_back, rsp_count;
  int unsigned            withhold_pct;

  fabric_top DUT (
    .clk_i, .rst_ni,
    .req_valid_i, .req_we_i, .req_addr_i, .req_wdata_i, .req_be_i,
    .req_credit_o, .rsp_credit_i,
    .rsp_valid_o, .rsp_rdata_o, .rsp_err_o
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic roll(output logic [31:0] r);
    stim_rng = xorshift(stim_rng);
    r = stim_rng;
  endtask

  task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s, got %h, expected %h",
               $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // expected {err, data} for one access
  function automatic logic [DataWidth:0] predict(input logic we,
                                                 input logic [AddrWidth-1:0] addr);
    logic [AddrWidth-1:0] word;
    if (addr >= RomBase && addr < RomBase + RomLength) begin
      if (we) begin
        return {1'b1, {DataWidth{1'b0}}};
      end
      word = (addr - RomBase) / StrbWidth;
      return {1'b0, RomImage[word[RomIdxBits-1:0]]};
    end
    if (addr >= SramBase && addr < SramBase + SramLength) begin
      if (we) begin
        return {1'b0, {DataWidth{1'b0}}};
      end
      word = (addr - SramBase) / StrbWidth;
      return {1'b0, sram_model[word[SramIdxBits-1:0]]};
    end
    return {1'b1, {DataWidth{1'b0}}};
  endfunction

  // one request, issued only while a request credit is held
  task automatic issue(input logic we, input logic [AddrWidth-1:0] addr,
                       input logic [DataWidth-1:0] wdata,
                       input logic [StrbWidth-1:0] be);
    logic [AddrWidth-1:0] word;
    while (req_credits == 0) begin
      req_valid_i = 1'b0;
      @(posedge clk_i);
      #1;
    end
    exp_q.push_back(predict(we, addr));
    if (we && addr >= SramBase && addr < SramBase + SramLength) begin
      word = (addr - SramBase) / StrbWidth;
      for (int b = 0; b < StrbWidth; b++) begin
        if (be[b]) begin
          sram_model[word[SramIdxBits-1:0]][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    req_credits--;
    issued++;
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // traffic phases
  // ----------------------------------------------------------------------
  task automatic rom_reads();
    logic [31:0] r;
    for (int i = 0; i < RomWords; i++) begin
      roll(r);
      issue(1'b0, RomBase + AddrWidth'(8 * i) + AddrWidth'(r[2:0]), '0, r[15:8]);
    end
  endtask

  // full write first so no byte is left undefined, then a merge and a read
  task automatic sram_traffic();
    logic [31:0]            r, d0, d1;
    logic [SramIdxBits-1:0] idx;
    logic [AddrWidth-1:0]   addr;
    for (int n = 0; n < NumSramWords; n++) begin
      roll(r);
      roll(d0);
      roll(d1);
      idx  = r[SramIdxBits-1:0];
      addr = SramBase + AddrWidth'({idx, 3'b000});
      written_q.push_back(idx);
      issue(1'b1, addr, {d0, d1}, {StrbWidth{1'b1}});
      issue(1'b1, addr + AddrWidth'(r[30:28]), {d1, d0 ^ r}, r[23:16]);
      issue(1'b0, addr + AddrWidth'(d0[2:0]), '0, d1[7:0]);
    end
  endtask

  task automatic error_traffic();
    logic [31:0]          r, d;
    logic [AddrWidth-1:0] edges [6];
    edges = '{RomBase - 8, RomBase + RomLength, SramBase - 8,
              SramBase + SramLength, 32'h0000_0000, 32'hffff_fff8};
    for (int i = 0; i < 6; i++) begin
      roll(r);
      issue(r[0], edges[i], {r, ~r}, r[15:8]);
    end
    // 0x4xxx_xxxx lies outside both windows
    for (int i = 0; i < NumUnmapped - 6; i++) begin
      roll(r);
      roll(d);
      issue(r[0], {4'h4, d[27:0]}, {d, r}, r[15:8]);
    end
    for (int i = 0; i < NumRomWrites; i++) begin
      roll(r);
      issue(1'b1, RomBase + AddrWidth'(r % RomLength), {r, ~r}, {StrbWidth{1'b1}});
    end
  endtask

  task automatic mixed_traffic();
    logic [31:0]            r, d0, d1;
    logic [SramIdxBits-1:0] idx;
    logic [AddrWidth-1:0]   sram_addr;
    for (int n = 0; n < NumMixed; n++) begin
      roll(r);
      roll(d0);
      roll(d1);
      idx       = written_q[d0 % written_q.size()];
      sram_addr = SramBase + AddrWidth'({idx, d1[2:0]});
      case (r[1:0])
        2'd0:    issue(1'b0, RomBase + AddrWidth'(d1 % RomLength), '0, r[15:8]);
        2'd1:    issue(1'b0, sram_addr, '0, r[15:8]);
        2'd2:    issue(1'b1, sram_addr, {d0, d1}, r[15:8]);
        default: begin
          if (r[2]) begin
            issue(r[3], {4'h4, d1[27:0]}, {d1, d0}, r[15:8]);
          end else begin
            issue(1'b1, RomBase + AddrWidth'(d1 % RomLength), {d0, d1}, r[15:8]);
          end
        end
      endcase
    end
  endtask

  // ----------------------------------------------------------------------
  // response credits with random withholding
  // ----------------------------------------------------------------------
  always begin
    @(posedge clk_i);
    #1;
    rsp_credit_i = 1'b0;
    credit_rng   = xorshift(credit_rng);
    if (rst_ni && free_slots > 0 && (credit_rng % 100) >= withhold_pct) begin
      rsp_credit_i = 1'b1;
      free_slots--;
      fab_credits++;
    end
  end

  // response compare and credit bookkeeping on the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (req_credit_o) begin
        req_credits++;
        credits_back++;
        check(64'(req_credits > ReqCredits), 64'd0, "request credit returned in excess");
      end
      if (rsp_valid_o) begin
        check(64'(fab_credits != 0), 64'd1, "response sent without a credit");
        check(64'(exp_q.size() != 0), 64'd1, "response with no request outstanding");
        exp_rsp = exp_q.pop_front();
        check(64'(rsp_err_o), 64'(exp_rsp[DataWidth]), "error flag");
        check(rsp_rdata_o, exp_rsp[DataWidth-1:0], "response data");
        fab_credits--;
        free_slots++;
        rsp_count++;
      end
    end
  end

  initial begin
    #(TimeLimit);
    $display("timeout: %0d of %0d responses seen at %0d ns", rsp_count, issued, $time);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    rsp_credit_i = 1'b0;
    stim_rng     = Seed;
    credit_rng   = xorshift(~Seed);
    req_credits  = ReqCredits;
    fab_credits  = RspCredits;
    free_slots   = 0;
    issued       = 0;
    credits_back = 0;
    rsp_count    = 0;
    withhold_pct = 0;

    repeat (ResetCycles) begin
      @(negedge clk_i);
      check(64'(req_credit_o), 64'd0, "credit pulse during reset");
      check(64'(rsp_valid_o), 64'd0, "response during reset");
    end
    @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check(64'(req_credit_o), 64'd0, "credit pulse after reset");
      check(64'(rsp_valid_o), 64'd0, "response after reset");
    end
    @(posedge clk_i);
    #1;

    rom_reads();
    withhold_pct = 30;
    sram_traffic();
    withhold_pct = 50;
    error_traffic();
    rom_reads();
    withhold_pct = 85;
    mixed_traffic();
    withhold_pct = 0;

    // every credit pulse precedes the response of the same request
    while (rsp_count != issued) begin
      @(negedge clk_i);
    end
    check(64'(credits_back), 64'(issued), "request credits returned after drain");

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
